// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ==========================================================================
// receiver sizing
// ==========================================================================

// copies per set. the pair flags and the vote mask are sized for five
`define RV_NUM_COPIES 5

// byte index of the copy ID within a frame, counting from 0
`define RV_ID_OFFSET 22

// payload bytes kept per copy, the rest is dropped
`define RV_BUF_DEPTH 256

// buffer address width, log2 of the depth
`define RV_ADDR_W 8

`endif

// File: verilog/rv_frame_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_frame_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [2:0] copy_id_t;                    // 1..5 valid
	typedef logic [`RV_ADDR_W-1:0] addr_t;

	// one bit wider than addr_t so that overflow past the depth shows
	typedef logic [`RV_ADDR_W:0] pay_idx_t;

	// ======================================================================
	// parser output, one event per cycle
	// ======================================================================
	typedef struct packed {
		logic     id_valid;                           // ID byte this cycle
		copy_id_t id;
		logic     pay_valid;                          // payload byte this cycle
		pay_idx_t pay_idx;                            // saturates at all ones
		byte_t    data;
		logic     frame_end;                          // rx_en has dropped
	} frame_beat_t;

	// write into one copy buffer
	typedef struct packed {
		logic     we;
		copy_id_t id;
		addr_t    addr;
		byte_t    data;
	} buf_wr_t;

endpackage

`default_nettype wire

// File: verilog/rv_vote_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_vote_pkg;

	import rv_frame_pkg::*;

	localparam int NUM_PAIRS = `RV_NUM_COPIES * (`RV_NUM_COPIES - 1) / 2;

	typedef logic [`RV_NUM_COPIES-1:0] copy_mask_t;   // bit 0 is copy 1
	typedef logic [NUM_PAIRS-1:0] pair_flags_t;       // 12,13,14,15,23,...,45

	// five bytes read at one shared address, element 0 is copy 1
	typedef byte_t [`RV_NUM_COPIES-1:0] rd_word_t;

	// stored length, up to and including the full depth
	typedef logic [`RV_ADDR_W:0] len_t;
	typedef len_t [`RV_NUM_COPIES-1:0] len_arr_t;

	// ======================================================================
	// outcome of one vote
	// ======================================================================
	typedef struct packed {
		logic     found;                              // some copy qualified
		copy_id_t winner;                             // 1..5, 0 when lost
		len_t     win_len;                            // bytes to replay
	} vote_result_t;

endpackage

`default_nettype wire

// File: verilog/frame_parser.sv
`default_nettype none

`include "rv_config.svh"

module frame_parser import rv_frame_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        rx_en,
	input  byte_t       rx_data,
	output frame_beat_t beat
);

	localparam int POS_W = $clog2(`RV_ID_OFFSET + 2);
	localparam logic [POS_W-1:0] POS_ID  = POS_W'(`RV_ID_OFFSET);
	localparam logic [POS_W-1:0] POS_PAY = POS_W'(`RV_ID_OFFSET + 1);

	logic             rx_en_q;
	byte_t            rx_data_q;
	logic [POS_W-1:0] pos_cnt;                        // stops once past the ID
	pay_idx_t         pay_cnt;
	logic             is_id;
	logic             is_pay;
	logic             is_end;

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
	end

	assign is_id  = rx_en_q && (pos_cnt == POS_ID);
	assign is_pay = rx_en_q && (pos_cnt == POS_PAY);
	assign is_end = !rx_en_q && (pos_cnt != '0);     // nonzero only after a frame

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_en_q <= 1'b0;
			pos_cnt <= '0;
			pay_cnt <= '0;
			beat    <= '0;
		end else begin
			rx_en_q <= rx_en;
			if (rx_en_q) begin
				if (pos_cnt != POS_PAY)
					pos_cnt <= pos_cnt + 1'b1;
				if (is_pay && (pay_cnt != '1))
					pay_cnt <= pay_cnt + 1'b1;    // hold at max on long frames
			end else begin
				pos_cnt <= '0;
				pay_cnt <= '0;
			end
			beat.id_valid  <= is_id;
			beat.id        <= rx_data_q[2:0];     // low bits carry the copy number
			beat.pay_valid <= is_pay;
			beat.pay_idx   <= pay_cnt;
			beat.data      <= rx_data_q;
			beat.frame_end <= is_end;
		end
	end

endmodule

`default_nettype wire

// File: verilog/set_tracker.sv
`default_nettype none

`include "rv_config.svh"

module set_tracker import rv_frame_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  frame_beat_t beat,
	input  logic        busy,
	output buf_wr_t     wr,
	output logic        set_close
);

	localparam copy_id_t LAST_ID = copy_id_t'(`RV_NUM_COPIES);

	copy_id_t cur_id;                                 // ID of the frame in flight
	copy_id_t max_id;                                 // 0 while the set is empty
	logic     accept;
	logic     id_ok;
	logic     in_range;

	assign id_ok    = (beat.id != '0) && (beat.id <= LAST_ID);
	assign in_range = beat.pay_idx < `RV_BUF_DEPTH;

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_id    <= '0;
			max_id    <= '0;
			accept    <= 1'b0;
			set_close <= 1'b0;
			wr        <= '0;
		end else begin
			set_close <= 1'b0;

			// ID byte decides whether this frame joins the open set
			if (beat.id_valid) begin
				if (busy || set_close || !id_ok) begin
					accept <= 1'b0;           // readout running or bad ID
				end else if (beat.id <= max_id) begin
					accept    <= 1'b0;        // repeat or lower ID, close and drop
					max_id    <= '0;
					set_close <= 1'b1;
				end else begin
					accept <= 1'b1;
					cur_id <= beat.id;
					max_id <= beat.id;
				end
			end

			// last copy of a set closes it as soon as it ends
			if (beat.frame_end) begin
				accept <= 1'b0;
				if (accept && (cur_id == LAST_ID)) begin
					max_id    <= '0;
					set_close <= 1'b1;
				end
			end

			wr.we   <= accept && beat.pay_valid && in_range;
			wr.id   <= cur_id;
			wr.addr <= beat.pay_idx[`RV_ADDR_W-1:0];
			wr.data <= beat.data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/copy_store.sv
`default_nettype none

`include "rv_config.svh"

module copy_store import rv_frame_pkg::*; import rv_vote_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  buf_wr_t    wr,
	input  logic       clear,
	input  addr_t      rd_addr,
	output rd_word_t   rd,
	output copy_mask_t present,
	output len_arr_t   lengths
);

	byte_t      mem [`RV_NUM_COPIES][`RV_BUF_DEPTH];
	copy_mask_t wr_sel;                               // one-hot copy select

	always_comb begin
		for (int c = 0; c < `RV_NUM_COPIES; c++)
			wr_sel[c] = wr.we && (wr.id == copy_id_t'(c + 1));
	end

	// ======================================================================
	// buffers, shared read address
	// ======================================================================
	always_ff @(posedge clk) begin
		for (int c = 0; c < `RV_NUM_COPIES; c++) begin
			if (wr_sel[c])
				mem[c][wr.addr] <= wr.data;
			rd[c] <= mem[c][rd_addr];             // one cycle read latency
		end
	end

	// presence and length per copy
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			present <= '0;
			lengths <= '0;
		end else begin
			for (int c = 0; c < `RV_NUM_COPIES; c++) begin
				if (wr_sel[c]) begin
					present[c] <= 1'b1;
					lengths[c] <= len_t'(wr.addr) + 1'b1; // last index plus one
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pair_compare.sv
`default_nettype none

`include "rv_config.svh"

module pair_compare import rv_frame_pkg::*; import rv_vote_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  rd_word_t     rd,
	input  logic         cmp_valid,
	input  logic         compare_last,
	input  copy_mask_t   present,
	input  len_arr_t     lengths,
	output vote_result_t result,
	output logic         result_valid
);

	pair_flags_t  flags;                              // byte agreement so far
	pair_flags_t  mismatch;
	pair_flags_t  pair_ok;                            // present and same length
	pair_flags_t  final_flags;
	len_t         cmp_idx;                            // address of the bytes in rd
	logic [2:0]   agree [`RV_NUM_COPIES];
	copy_mask_t   qualify;
	vote_result_t vote;

	// ======================================================================
	// pairwise checks, pair order 12,13,14,15,23,24,25,34,35,45
	// ======================================================================
	always_comb begin
		int p;
		p = 0;
		mismatch = '0;
		pair_ok  = '0;
		for (int i = 0; i < `RV_NUM_COPIES; i++) begin
			for (int j = i + 1; j < `RV_NUM_COPIES; j++) begin
				pair_ok[p]  = present[i] && present[j] && (lengths[i] == lengths[j]);
				mismatch[p] = (rd[i] != rd[j]) &&
				              (cmp_idx < lengths[i]) && (cmp_idx < lengths[j]);
				p = p + 1;
			end
		end
	end

	assign final_flags = flags & pair_ok;

	// agreements per copy, lowest qualifying copy wins
	always_comb begin
		int p;
		p = 0;
		for (int c = 0; c < `RV_NUM_COPIES; c++)
			agree[c] = '0;
		for (int i = 0; i < `RV_NUM_COPIES; i++) begin
			for (int j = i + 1; j < `RV_NUM_COPIES; j++) begin
				if (final_flags[p]) begin
					agree[i] = agree[i] + 1'b1;
					agree[j] = agree[j] + 1'b1;
				end
				p = p + 1;
			end
		end
		for (int c = 0; c < `RV_NUM_COPIES; c++)
			qualify[c] = agree[c] >= 3'd2;
		vote = '0;
		for (int c = `RV_NUM_COPIES - 1; c >= 0; c--) begin
			if (qualify[c]) begin
				vote.found   = 1'b1;
				vote.winner  = copy_id_t'(c + 1);
				vote.win_len = lengths[c];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags        <= '1;
			cmp_idx      <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= compare_last;
			if (compare_last) begin
				flags   <= '1;                    // ready for the next set
				cmp_idx <= '0;
			end else if (cmp_valid) begin
				flags   <= flags & ~mismatch;
				cmp_idx <= cmp_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (compare_last)
			result <= vote;
	end

endmodule

`default_nettype wire

// File: verilog/readout_sequencer.sv
`default_nettype none

`include "rv_config.svh"

module readout_sequencer import rv_frame_pkg::*; import rv_vote_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         set_close,
	input  rd_word_t     rd,
	input  len_arr_t     lengths,
	input  vote_result_t result,
	input  logic         result_valid,
	output addr_t        rd_addr,
	output logic         cmp_valid,
	output logic         compare_last,
	output logic         clear,
	output logic         busy,
	output logic         out_valid,
	output byte_t        out_data,
	output logic         lost
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_COMPARE,
		S_WAIT_RES,
		S_REPLAY,
		S_FINISH
	} state_t;

	state_t     state;
	len_t       cnt;                                  // read address counter
	len_t       max_len;
	logic       end_cmp;
	logic       cmp_last_d;
	logic       rep_d;                                // replay byte in rd
	logic [2:0] win_sel;

	always_comb begin
		max_len = '0;
		for (int c = 0; c < `RV_NUM_COPIES; c++)
			if (lengths[c] > max_len)
				max_len = lengths[c];
	end

	assign rd_addr = cnt[`RV_ADDR_W-1:0];
	assign end_cmp = (state == S_COMPARE) &&
	                 ((max_len == '0) || (cnt == max_len - 1'b1));
	assign busy    = state != S_IDLE;
	assign clear   = state == S_FINISH;
	assign win_sel = result.winner - 1'b1;

	// ======================================================================
	// compare pass, then replay of the winning copy
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= S_IDLE;
			cnt          <= '0;
			cmp_valid    <= 1'b0;
			cmp_last_d   <= 1'b0;
			compare_last <= 1'b0;
			rep_d        <= 1'b0;
			out_valid    <= 1'b0;
			lost         <= 1'b0;
		end else begin
			cmp_valid    <= (state == S_COMPARE) && (cnt < max_len); // lines up with rd
			cmp_last_d   <= end_cmp;
			compare_last <= cmp_last_d;           // after the last cmp_valid
			rep_d        <= state == S_REPLAY;
			out_valid    <= rep_d;
			lost         <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (set_close)
						state <= S_COMPARE;
				end
				S_COMPARE: begin
					if (end_cmp)
						state <= S_WAIT_RES;
					else
						cnt <= cnt + 1'b1;
				end
				S_WAIT_RES: begin
					cnt <= '0;
					if (result_valid) begin
						if (result.found) begin
							state <= S_REPLAY;
						end else begin
							lost  <= 1'b1;    // no copy has two supporters
							state <= S_FINISH;
						end
					end
				end
				S_REPLAY: begin
					if (cnt == result.win_len - 1'b1)
						state <= S_FINISH;
					else
						cnt <= cnt + 1'b1;
				end
				S_FINISH: state <= S_IDLE;
				default:  state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rep_d)
			out_data <= rd[win_sel];
	end

endmodule

`default_nettype wire

// File: verilog/redundant_rx_top.sv
`default_nettype none

module redundant_rx_top import rv_frame_pkg::*; import rv_vote_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  rx_en,
	input  byte_t rx_data,
	output logic  out_valid,
	output byte_t out_data,
	output logic  lost
);

	frame_beat_t  beat;
	buf_wr_t      wr;
	logic         set_close;
	logic         busy;
	logic         clear;
	addr_t        rd_addr;
	rd_word_t     rd;
	copy_mask_t   present;
	len_arr_t     lengths;
	logic         cmp_valid;
	logic         compare_last;
	vote_result_t result;
	logic         result_valid;

	// ======================================================================
	// receive side
	// ======================================================================
	frame_parser u_parser (
		.clk     (clk),
		.rst     (rst),
		.rx_en   (rx_en),
		.rx_data (rx_data),
		.beat    (beat)
	);

	set_tracker u_tracker (
		.clk       (clk),
		.rst       (rst),
		.beat      (beat),
		.busy      (busy),
		.wr        (wr),
		.set_close (set_close)
	);

	copy_store u_store (
		.clk     (clk),
		.rst     (rst),
		.wr      (wr),
		.clear   (clear),
		.rd_addr (rd_addr),
		.rd      (rd),
		.present (present),
		.lengths (lengths)
	);

	// ======================================================================
	// vote and replay
	// ======================================================================
	pair_compare u_compare (
		.clk          (clk),
		.rst          (rst),
		.rd           (rd),
		.cmp_valid    (cmp_valid),
		.compare_last (compare_last),
		.present      (present),
		.lengths      (lengths),
		.result       (result),
		.result_valid (result_valid)
	);

	readout_sequencer u_sequencer (
		.clk          (clk),
		.rst          (rst),
		.set_close    (set_close),
		.rd           (rd),
		.lengths      (lengths),
		.result       (result),
		.result_valid (result_valid),
		.rd_addr      (rd_addr),
		.cmp_valid    (cmp_valid),
		.compare_last (compare_last),
		.clear        (clear),
		.busy         (busy),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.lost         (lost)
	);

endmodule

`default_nettype wire

// File: sim/tb_redundant_rx.sv
`default_nettype none

`include "rv_config.svh"

module tb_redundant_rx import rv_frame_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NCOP    = `RV_NUM_COPIES;
	localparam int MAX_PAY = 64;                      // room for the longest test payload
	localparam int TIMEOUT = 2000;                    // cycles per wait

	logic  clk;
	logic  rst;
	logic  rx_en;
	byte_t rx_data;
	logic  out_valid;
	byte_t out_data;
	logic  lost;

	integer seed;
	int     checks       = 0;
	int     mismatches   = 0;
	int     other_errors = 0;
	int     got_bytes    = 0;                         // output bytes seen so far
	int     lost_seen    = 0;
	int     exp_lost     = 0;
	byte_t  exp_bytes [$];

	byte_t sent_pay  [NCOP*MAX_PAY];                  // slot c at c*MAX_PAY
	int    sent_len  [NCOP];
	bit    sent_pres [NCOP];

	redundant_rx_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.rx_en     (rx_en),
		.rx_data   (rx_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.lost      (lost)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==========================================================================
	// random values and the vote model
	// ==========================================================================
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[15:0]) % n;
	endfunction

	function automatic byte_t rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic int rand_len();
		return 8 + rand_below(33);                    // 8 to 40 bytes
	endfunction

	// slot of the expected winner or -1 when no copy has two supporters
	function automatic int expected_winner(input byte_t pay [NCOP*MAX_PAY],
	                                       input int len [NCOP], input bit pres [NCOP]);
		int agree;
		bit same;
		for (int i = 0; i < NCOP; i++) begin
			agree = 0;
			for (int j = 0; j < NCOP; j++) begin
				if ((j != i) && pres[i] && pres[j] && (len[i] == len[j])) begin
					same = 1'b1;
					for (int k = 0; k < len[i]; k++)
						if (pay[i*MAX_PAY+k] != pay[j*MAX_PAY+k])
							same = 1'b0;
					if (same)
						agree++;
				end
			end
			if (agree >= 2)
				return i;                             // lowest qualifying copy
		end
		return -1;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
	                           input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
			         $time, what, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, mismatches %0d, other errors %0d",
		         checks, mismatches, other_errors);
	endtask

	task automatic fail_timeout(input string what);
		$display("ERROR at %0t ns: timed out while %s", $time, what);
		report_counts();
		$display("Result: FAILED");
		$finish;
	endtask

	// output bytes and lost pulses are sampled mid-cycle
	always @(negedge clk) begin : compare_outputs
		if (!rst) begin
			if (out_valid) begin
				if (got_bytes >= exp_bytes.size()) begin
					other_errors++;
					$display("ERROR at %0t ns: output byte 0x%0h came when none was expected",
					         $time, out_data);
				end else begin
					check_value(out_data, exp_bytes[got_bytes], "replayed byte");
				end
				got_bytes++;
			end
			if (lost) begin
				if (lost_seen >= exp_lost) begin
					other_errors++;
					$display("ERROR at %0t ns: lost pulsed for a set that has a winner", $time);
				end
				lost_seen++;
			end
		end
	end

	// ==========================================================================
	// frame stimulus
	// ==========================================================================
	task automatic drive_byte(input byte_t b);
		@(negedge clk);
		rx_en   = 1'b1;
		rx_data = b;
	endtask

	task automatic idle_gap();
		repeat (3) begin
			@(negedge clk);
			rx_en   = 1'b0;
			rx_data = '0;
		end
	endtask

	// random header, ID byte, then the payload held in slot c
	task automatic send_copy(input int c);
		byte_t b;
		for (int i = 0; i < `RV_ID_OFFSET; i++)
			drive_byte(rand_byte());
		b      = rand_byte();
		b[2:0] = copy_id_t'(c + 1);                  // upper bits are don't care
		drive_byte(b);
		for (int k = 0; k < sent_len[c]; k++)
			drive_byte(sent_pay[c*MAX_PAY+k]);
		idle_gap();
	endtask

	// random frame of nbytes with the ID byte placed if the frame reaches it
	task automatic send_junk(input copy_id_t id, input int nbytes);
		byte_t b;
		for (int i = 0; i < nbytes; i++) begin
			b = rand_byte();
			if (i == `RV_ID_OFFSET)
				b[2:0] = id;
			drive_byte(b);
		end
		idle_gap();
	endtask

	task automatic fill_copies(input int len);
		for (int k = 0; k < len; k++) begin
			sent_pay[k] = rand_byte();
			for (int c = 1; c < NCOP; c++)
				sent_pay[c*MAX_PAY+k] = sent_pay[k];
		end
		for (int c = 0; c < NCOP; c++)
			sent_len[c] = len;
	endtask

	task automatic expect_vote(input logic [NCOP-1:0] mask);
		int w;
		for (int c = 0; c < NCOP; c++)
			sent_pres[c] = mask[c];
		w = expected_winner(sent_pay, sent_len, sent_pres);
		if (w < 0)
			exp_lost++;
		else
			for (int k = 0; k < sent_len[w]; k++)
				exp_bytes.push_back(sent_pay[w*MAX_PAY+k]);
	endtask

	function automatic bit set_pending();
		return (got_bytes < exp_bytes.size()) || (lost_seen < exp_lost);
	endfunction

	task automatic wait_set_done(input string what);
		int t;
		t = 0;
		while (set_pending() && (t < TIMEOUT)) begin
			@(posedge clk);
			t++;
		end
		if (set_pending())
			fail_timeout({"waiting for the output of ", what});
		t = 0;
		while (u_dut.busy && (t < TIMEOUT)) begin
			@(negedge clk);
			t++;
		end
		if (u_dut.busy)
			fail_timeout({"waiting for the receiver to go idle after ", what});
		repeat (4) @(posedge clk);
	endtask

	// sends the masked copies in order and copy 5 closes the set
	task automatic run_set(input logic [NCOP-1:0] mask, input string what);
		expect_vote(mask);
		for (int c = 0; c < NCOP; c++)
			if (mask[c])
				send_copy(c);
		wait_set_done(what);
	endtask

	// ==========================================================================
	// test sequence
	// ==========================================================================
	initial begin
		int len;
		int pos;
		seed    = 57;
		rst     = 1'b1;
		rx_en   = 1'b0;
		rx_data = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value(out_valid, 1'b0, "out_valid after reset");
		check_value(lost, 1'b0, "lost after reset");

		fill_copies(rand_len());
		run_set(5'b11111, "five identical copies");

		for (int c = 0; c < NCOP; c++) begin
			len = rand_len();
			fill_copies(len);
			pos = c*MAX_PAY + rand_below(len);
			sent_pay[pos] = sent_pay[pos] ^ (rand_byte() | 8'h01); // flip at least one bit
			run_set(5'b11111, "one corrupted copy");
		end

		fill_copies(rand_len());
		run_set(5'b11001, "copies 2 and 3 missing");
		fill_copies(rand_len());
		run_set(5'b10001, "three copies missing");

		// ID 2 after copies 1..3 closes the set early
		len = rand_len();
		fill_copies(len);
		expect_vote(5'b00111);
		for (int c = 0; c < 3; c++)
			send_copy(c);
		send_junk(3'd2, `RV_ID_OFFSET + 1 + len);
		wait_set_done("early closed set");
		fill_copies(rand_len());
		run_set(5'b11111, "set after an early close");

		// longer copy 1, ID 7 frame and a frame cut before the ID byte
		len = rand_len();
		fill_copies(len);
		sent_len[0] = len + 2;
		sent_pay[len]     = rand_byte();
		sent_pay[len + 1] = rand_byte();
		expect_vote(5'b11111);
		send_copy(0);
		send_junk(3'd7, `RV_ID_OFFSET + 11);
		send_junk(3'd0, 10);
		for (int c = 1; c < NCOP; c++)
			send_copy(c);
		wait_set_done("lengths and invalid ID");

		fill_copies(30);
		sent_len[0] = 12;
		sent_len[1] = 12;
		sent_len[2] = 20;
		sent_len[3] = 20;
		run_set(5'b11111, "only length pairs agree");

		repeat (10) @(posedge clk);
		check_value(got_bytes, exp_bytes.size(), "output byte count");
		check_value(lost_seen, exp_lost, "lost pulse count");
		report_counts();
		if ((mismatches == 0) && (other_errors == 0))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/rv_frame_pkg.sv
verilog/rv_vote_pkg.sv
verilog/frame_parser.sv
verilog/set_tracker.sv
verilog/copy_store.sv
verilog/pair_compare.sv
verilog/readout_sequencer.sv
verilog/redundant_rx_top.sv
sim/tb_redundant_rx.sv

// File: Bender.yml
package:
  name: redundant_rx

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_frame_pkg.sv
      - verilog/rv_vote_pkg.sv
      - verilog/frame_parser.sv
      - verilog/set_tracker.sv
      - verilog/copy_store.sv
      - verilog/pair_compare.sv
      - verilog/readout_sequencer.sv
      - verilog/redundant_rx_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_redundant_rx.sv
